/* filelist.f */
source/bru_pkg.sv
source/predict_stage.sv
source/decode_stage.sv
source/resolve_stage.sv
source/branch_pipeline_top.sv
verif/branch_checker.sv
verif/tb_branch_pipeline.sv

/* verif/tb_branch_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_branch_pipeline;

    import bru_pkg::*;

    localparam int RUN_CYCLES   = 2000;
    localparam int DRAIN_CYCLES = 20;

    logic        clk;
    logic        rst_n;
    in_t         in;
    res_t        res;
    logic [31:0] lfsr;
    logic [31:0] slot_instr [8];
    int          error_count;
    int          result_count;
    int          pending;
    int          waited;

    branch_pipeline_top #(.INDEX_BITS (4)) u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (in),
        .res   (res)
    );

    branch_checker #(.INDEX_BITS (4)) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (in),
        .res          (res),
        .error_count  (error_count),
        .result_count (result_count),
        .pending      (pending)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Both regions land on the same BTB index with different tags
    function automatic logic [31:0] pool_pc(logic [2:0] sel);
        return (sel[2] ? 32'h0000_2000 : 32'h0000_1000) + {26'd0, sel[1:0], 4'h4};
    endfunction

    function automatic logic [31:0] pick_operand(logic [2:0] sel);
        case (sel)
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h0000_0001;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h8000_0000;
            3'd4:    return 32'h7fff_ffff;
            3'd5:    return 32'hffff_fffe;
            3'd6:    return 32'h0000_1003;
            default: return 32'h0000_0001;
        endcase
    endfunction

    task automatic new_word(input logic [2:0] slot);
        logic [31:0] r;
        r = take_bits(25);
        slot_instr[slot] = {r[24:0], 7'd0};
        r = take_bits(3);
        case (r[2:0])
            3'd4:       slot_instr[slot][6:0] = OP_JAL;
            3'd5:       slot_instr[slot][6:0] = OP_JALR;
            3'd6, 3'd7: slot_instr[slot][6:0] = OP_ALU;
            default:    slot_instr[slot][6:0] = OP_BRANCH;
        endcase
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [2:0]  slot;
        r = take_bits(2);
        in.valid = (r[1:0] != 2'b00);
        r = take_bits(3);
        slot = r[2:0];
        r = take_bits(3);
        // Words mostly stay put so the predictor has something to learn
        if (r[2:0] == 3'd0)
            new_word(slot);
        in.pc    = pool_pc(slot);
        in.instr = slot_instr[slot];
        r = take_bits(3);
        in.rs1 = pick_operand(r[2:0]);
        r = take_bits(3);
        in.rs2 = pick_operand(r[2:0]);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        in    = '0;
        lfsr  = 32'hb20d8926;
        for (int i = 0; i < 8; i++) begin
            new_word(i[2:0]);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (RUN_CYCLES) begin
            drive_random();
            @(negedge clk);
        end
        in.valid = 1'b0;
        waited   = 0;
        while (pending != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0)
            $display("Timeout: %0d results still outstanding after drain", pending);
        $display("Results checked %0d, errors %0d, missing %0d",
                 result_count, error_count, pending);
        if (pending != 0 || error_count != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/branch_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_checker #(
    parameter int INDEX_BITS = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  bru_pkg::in_t  in,
    input  bru_pkg::res_t res,
    output int            error_count,
    output int            result_count,
    output int            pending
);

    import bru_pkg::*;

    localparam int ENTRIES = 1 << INDEX_BITS;

    typedef struct packed {
        logic [31:0] due;
        logic        ctrl;
        res_t        exp;
    } item_t;

    // Reference predictor
    logic        m_valid  [ENTRIES];
    logic [31:0] m_tag    [ENTRIES];
    logic [31:0] m_target [ENTRIES];
    logic [1:0]  m_ctr    [ENTRIES];
    item_t       queue [$];
    int          cycle;

    function automatic logic [31:0] imm_of(logic [31:0] w);
        case (w[6:0])
            OP_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OP_JAL:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:   return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic res_t expected_result(in_t i, logic pt, logic [31:0] ptgt);
        res_t        r;
        logic [31:0] w;
        logic [31:0] imm;
        w            = i.instr;
        imm          = imm_of(w);
        r.valid      = 1'b1;
        r.pc         = i.pc;
        r.is_jump    = (w[6:0] == OP_JAL) || (w[6:0] == OP_JALR);
        r.taken      = r.is_jump ||
                       ((w[6:0] == OP_BRANCH) && branch_taken(w[14:12], i.rs1, i.rs2));
        if (w[6:0] == OP_JALR)
            r.target = (i.rs1 + imm) & ~32'h1;
        else if (r.taken)
            r.target = i.pc + imm;
        else
            r.target = i.pc + 32'd4;
        r.link       = r.is_jump ? i.pc + 32'd4 : 32'd0;
        r.mispredict = (r.target != ptgt) || (r.taken != pt);
        return r;
    endfunction

    task automatic check_field(string name, logic [31:0] pc, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            error_count++;
            $display("CHECK FAILED at %0t: pc %h field %s expected %h got %h",
                     $time, pc, name, exp, got);
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Compare, then lookup, then update
    //////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        item_t item;
        item_t done;
        logic  apply;
        int    li;
        int    ui;
        logic  pt;
        apply = 1'b0;
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                m_valid[i] = 1'b0;
                m_ctr[i]   = 2'd0;
            end
            queue.delete();
        end else begin
            cycle++;
            if (res.valid) begin
                if (queue.size() == 0) begin
                    error_count++;
                    $display("Result for pc %h at %0t came with no instruction in flight",
                             res.pc, $time);
                end else begin
                    done  = queue.pop_front();
                    apply = done.ctrl;
                    result_count++;
                    if (done.due != cycle) begin
                        error_count++;
                        $display("Result for pc %h at %0t came at the wrong latency",
                                 res.pc, $time);
                    end
                    check_field("pc", done.exp.pc, done.exp.pc, res.pc);
                    check_field("taken", done.exp.pc, done.exp.taken, res.taken);
                    check_field("target", done.exp.pc, done.exp.target, res.target);
                    check_field("link", done.exp.pc, done.exp.link, res.link);
                    check_field("is_jump", done.exp.pc, done.exp.is_jump, res.is_jump);
                    check_field("mispredict", done.exp.pc, done.exp.mispredict, res.mispredict);
                end
            end else if (queue.size() != 0 && queue[0].due <= cycle) begin
                done  = queue.pop_front();
                apply = done.ctrl;
                error_count++;
                $display("No result for pc %h by %0t, three cycles after its strobe",
                         done.exp.pc, $time);
            end
            if (in.valid) begin
                li        = in.pc[INDEX_BITS+1:2];
                pt        = m_valid[li] && (m_tag[li] == (in.pc >> (INDEX_BITS + 2))) &&
                            m_ctr[li][1];
                item.due  = cycle + 3;
                item.ctrl = (in.instr[6:0] == OP_BRANCH) || (in.instr[6:0] == OP_JAL) ||
                            (in.instr[6:0] == OP_JALR);
                item.exp  = expected_result(in, pt, pt ? m_target[li] : in.pc + 32'd4);
                queue.push_back(item);
            end
            if (apply) begin
                ui = done.exp.pc[INDEX_BITS+1:2];
                if (m_valid[ui] && m_tag[ui] == (done.exp.pc >> (INDEX_BITS + 2))) begin
                    if (done.exp.taken) begin
                        m_ctr[ui]    = (m_ctr[ui] == 2'd3) ? 2'd3 : m_ctr[ui] + 2'd1;
                        m_target[ui] = done.exp.target;
                    end else begin
                        m_ctr[ui]    = (m_ctr[ui] == 2'd0) ? 2'd0 : m_ctr[ui] - 2'd1;
                    end
                end else if (done.exp.taken) begin
                    m_valid[ui]  = 1'b1;
                    m_tag[ui]    = done.exp.pc >> (INDEX_BITS + 2);
                    m_target[ui] = done.exp.target;
                    m_ctr[ui]    = 2'd2;
                end
            end
        end
        pending = queue.size();
    end

endmodule

`default_nettype wire

/* source/branch_pipeline_top.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_pipeline_top #(
    parameter int INDEX_BITS = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  bru_pkg::in_t  in,
    output bru_pkg::res_t res
);

    import bru_pkg::*;

    ////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////

    pred_t pred;
    dec_t  dec;

    // Feedback from resolve into the predictor
    upd_t  upd;

    predict_stage #(
        .INDEX_BITS (INDEX_BITS)
    ) u_predict (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (in),
        .upd   (upd),
        .pred  (pred)
    );

    decode_stage u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .pred  (pred),
        .dec   (dec)
    );

    resolve_stage u_resolve (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec),
        .res   (res),
        .upd   (upd)
    );

endmodule

`default_nettype wire

/* source/resolve_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module resolve_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  bru_pkg::dec_t dec,
    output bru_pkg::res_t res,
    output bru_pkg::upd_t upd
);

    import bru_pkg::*;

    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jalr_target;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            is_jump;
    logic            is_ctrl;
    logic            mispredict;

    ////////////////////////////////////////////////////////////
    // Outcome
    ////////////////////////////////////////////////////////////

    assign seq_pc        = dec.pc + 32'h4;
    // Shared by JAL and taken branches
    assign branch_target = dec.pc + dec.imm;
    // JALR drops bit 0 of the sum
    assign jalr_target   = (dec.rs1 + dec.imm) & ~32'h1;

    assign is_jump = (dec.opcode == OP_JAL) || (dec.opcode == OP_JALR);
    assign is_ctrl = is_jump || (dec.opcode == OP_BRANCH);
    assign link    = is_jump ? seq_pc : '0;

    always_comb begin
        if (dec.opcode == OP_BRANCH) begin
            case (dec.funct3)
                F3_BEQ:  taken = (dec.rs1 == dec.rs2);
                F3_BNE:  taken = (dec.rs1 != dec.rs2);
                F3_BLT:  taken = ($signed(dec.rs1) < $signed(dec.rs2));
                F3_BGE:  taken = ($signed(dec.rs1) >= $signed(dec.rs2));
                F3_BLTU: taken = (dec.rs1 < dec.rs2);
                F3_BGEU: taken = (dec.rs1 >= dec.rs2);
                default: taken = 1'b0;
            endcase
        end else if (is_jump) begin
            taken = 1'b1;
        end else begin
            taken = 1'b0;
        end
    end

    always_comb begin
        if (dec.opcode == OP_JALR) begin
            target = jalr_target;
        end else if (taken) begin
            target = branch_target;
        end else begin
            target = seq_pc;
        end
    end

    // Checked for every opcode, not only control transfers
    assign mispredict = (target != dec.pred_target) || (taken != dec.pred_taken);

    ////////////////////////////////////////////////////////////
    // Result and predictor update registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        res.pc         <= dec.pc;
        res.taken      <= taken;
        res.target     <= target;
        res.link       <= link;
        res.is_jump    <= is_jump;
        res.mispredict <= mispredict;
        upd.pc         <= dec.pc;
        upd.taken      <= taken;
        upd.target     <= target;
        if (!rst_n) begin
            res.valid <= 1'b0;
            upd.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid;
            upd.valid <= dec.valid && is_ctrl;
        end
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  bru_pkg::pred_t pred,
    output bru_pkg::dec_t  dec
);

    import bru_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm;

    // Opcode sits at the same bits in every format
    assign opcode = pred.instr.i_fmt.opcode;
    assign funct3 = pred.instr.b_fmt.funct3;

    ////////////////////////////////////////////////////////////
    // Immediates per format
    ////////////////////////////////////////////////////////////

    assign imm_b = {
        {19{pred.instr.b_fmt.imm_12}},
        pred.instr.b_fmt.imm_12,
        pred.instr.b_fmt.imm_11,
        pred.instr.b_fmt.imm_10_5,
        pred.instr.b_fmt.imm_4_1,
        1'b0
    };

    assign imm_j = {
        {11{pred.instr.j_fmt.imm_20}},
        pred.instr.j_fmt.imm_20,
        pred.instr.j_fmt.imm_19_12,
        pred.instr.j_fmt.imm_11,
        pred.instr.j_fmt.imm_10_1,
        1'b0
    };

    assign imm_i = {
        {20{pred.instr.i_fmt.imm_11_0[11]}},
        pred.instr.i_fmt.imm_11_0
    };

    always_comb begin
        case (opcode)
            OP_BRANCH: imm = imm_b;
            OP_JAL:    imm = imm_j;
            default:   imm = imm_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        dec.pc          <= pred.pc;
        dec.rs1         <= pred.rs1;
        dec.rs2         <= pred.rs2;
        dec.pred_taken  <= pred.pred_taken;
        dec.pred_target <= pred.pred_target;
        dec.opcode      <= opcode;
        dec.funct3      <= funct3;
        dec.imm         <= imm;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= pred.valid;
        end
    end

endmodule

`default_nettype wire

/* source/predict_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module predict_stage #(
    parameter int INDEX_BITS = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  bru_pkg::in_t  in,
    input  bru_pkg::upd_t upd,
    output bru_pkg::pred_t pred
);

    import bru_pkg::*;

    localparam int ENTRIES  = 1 << INDEX_BITS;
    localparam int TAG_BITS = XLEN - INDEX_BITS - 2;

    ////////////////////////////////////////////////////////////
    // Branch target buffer
    ////////////////////////////////////////////////////////////

    logic                entry_valid  [ENTRIES];
    logic [TAG_BITS-1:0] entry_tag    [ENTRIES];
    logic [XLEN-1:0]     entry_target [ENTRIES];
    logic [1:0]          entry_ctr    [ENTRIES];

    // Lookup side
    logic [INDEX_BITS-1:0] lu_idx;
    logic [TAG_BITS-1:0]   lu_tag;
    logic                  lu_hit;
    logic                  lu_taken;
    logic [XLEN-1:0]       lu_target;

    // Update side
    logic [INDEX_BITS-1:0] up_idx;
    logic [TAG_BITS-1:0]   up_tag;
    logic                  up_hit;

    assign lu_idx = in.pc[INDEX_BITS+1:2];
    assign lu_tag = in.pc[XLEN-1:INDEX_BITS+2];
    assign lu_hit = entry_valid[lu_idx] && (entry_tag[lu_idx] == lu_tag);

    // Counter msb set means weakly or strongly taken
    assign lu_taken  = lu_hit && entry_ctr[lu_idx][1];
    assign lu_target = lu_taken ? entry_target[lu_idx] : in.pc + 32'h4;

    assign up_idx = upd.pc[INDEX_BITS+1:2];
    assign up_tag = upd.pc[XLEN-1:INDEX_BITS+2];
    assign up_hit = entry_valid[up_idx] && (entry_tag[up_idx] == up_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
                entry_ctr[i]   <= 2'd0;
            end
        end else if (upd.valid) begin
            if (up_hit) begin
                if (upd.taken && entry_ctr[up_idx] != 2'd3) begin
                    entry_ctr[up_idx] <= entry_ctr[up_idx] + 2'd1;
                end else if (!upd.taken && entry_ctr[up_idx] != 2'd0) begin
                    entry_ctr[up_idx] <= entry_ctr[up_idx] - 2'd1;
                end
            end else if (upd.taken) begin
                // Allocate weakly taken
                entry_valid[up_idx] <= 1'b1;
                entry_ctr[up_idx]   <= 2'd2;
            end
        end
    end

    // On a hit the tag rewrite is a no-op
    always_ff @(posedge clk) begin
        if (upd.valid && upd.taken) begin
            entry_tag[up_idx]    <= up_tag;
            entry_target[up_idx] <= upd.target;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        pred.pc          <= in.pc;
        pred.instr       <= in.instr;
        pred.rs1         <= in.rs1;
        pred.rs2         <= in.rs2;
        pred.pred_taken  <= lu_taken;
        pred.pred_target <= lu_target;
        if (!rst_n) begin
            pred.valid <= 1'b0;
        end else begin
            pred.valid <= in.valid;
        end
    end

endmodule

`default_nettype wire

/* source/bru_pkg.sv */
`default_nettype none

package bru_pkg;

    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////
    // Opcodes and branch conditions
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_ALU    = 7'b0110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same 32 bits, read per format
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
    } in_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
    } pred_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [XLEN-1:0] imm;
    } dec_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            taken;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] link;
        logic            is_jump;
        logic            mispredict;
    } res_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            taken;
        logic [XLEN-1:0] target;
    } upd_t;

endpackage

`default_nettype wire
